// ==== vlog.f ====
+incdir+include
rtl/du_pkg.sv
rtl/du_bp_if.sv
rtl/du_access_decode.sv
rtl/du_regs.sv
rtl/du_bp_match.sv
rtl/du_hit_ctrl.sv
rtl/du_readback.sv
rtl/du_top.sv
testbench/du_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f --top-module du_tb -o du_sim &&
./obj_dir/du_sim | tee /dev/stderr | grep -q "sim passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }

// ==== testbench/du_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "du_params.svh"

module du_tb;

  localparam du_pkg::word_t HitMask = 32'h3 | du_pkg::word_t'(((1 << `DU_BREAKPOINTS) - 1) << 8);

  logic              clk_i;
  logic              rst_ni;
  logic              dbg_stall_i;
  logic              dbg_strb_i;
  logic              dbg_we_i;
  du_pkg::dbg_addr_t dbg_addr_i;
  du_pkg::word_t     dbg_d_i;
  du_pkg::word_t     dbg_q_o;
  logic              dbg_ack_o;
  logic              dbg_bp_o;
  logic              du_stall_o;
  logic              du_latch_nxt_pc_o;
  logic              du_flush_o;
  du_pkg::word_t     du_ie_o;
  du_pkg::word_t     pd_pc_i;
  logic              bu_flush_i;
  logic              st_flush_i;
  du_pkg::opcode_t   if_opcode_i;
  logic              if_bubble_i;
  du_pkg::opcode_t   mem_opcode_i;
  logic              mem_bubble_i;
  logic              mem_exception_i;
  du_pkg::word_t     mem_adr_i;
  logic              dmem_ack_i;
  du_pkg::exc_vec_t  du_exceptions_i;

  // Shadow of the internal register bank
  logic [1:0]        sh_ctrl;
  du_pkg::word_t     sh_ie;
  du_pkg::word_t     sh_cause;
  du_pkg::word_t     sh_hit;
  logic              sh_en   [`DU_BREAKPOINTS];
  logic [2:0]        sh_cc   [`DU_BREAKPOINTS];
  du_pkg::word_t     sh_data [`DU_BREAKPOINTS];

  du_top du_top_inst (.*);

  always #20 clk_i = ~clk_i;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic du_pkg::dbg_addr_t internal_addr(input du_pkg::reg_ofs_t ofs);
    return {`DU_BANK_INTERNAL, ofs};
  endfunction

  function automatic du_pkg::dbg_addr_t bpctrl_addr(input int n);
    return internal_addr(du_pkg::reg_ofs_t'(`DU_REG_BPCTRL0 + 2 * n));
  endfunction

  function automatic du_pkg::dbg_addr_t bpdata_addr(input int n);
    return internal_addr(du_pkg::reg_ofs_t'(`DU_REG_BPDATA0 + 2 * n));
  endfunction

  function automatic du_pkg::word_t ref_rdata(input du_pkg::dbg_addr_t addr);
    du_pkg::reg_ofs_t ofs;
    du_pkg::word_t    r;
    ofs = addr[`DU_REG_W-1:0];
    r   = '0;
    if (addr[`DU_ADDR_W-1:`DU_REG_W] != `DU_BANK_INTERNAL)
      r = '0;
    else if (ofs == `DU_REG_CTRL)
      r = {30'b0, sh_ctrl};
    else if (ofs == `DU_REG_HIT)
      r = sh_hit;
    else if (ofs == `DU_REG_IE)
      r = sh_ie;
    else if (ofs == `DU_REG_CAUSE)
      r = sh_cause;
    else
      // Slots above the implemented count stay zero
      for (int n = 0; n < `DU_BREAKPOINTS; n++)
      begin
        if (ofs == du_pkg::reg_ofs_t'(`DU_REG_BPCTRL0 + 2 * n))
          r = {25'b0, sh_cc[n], 2'b0, sh_en[n], 1'b1};
        if (ofs == du_pkg::reg_ofs_t'(`DU_REG_BPDATA0 + 2 * n))
          r = sh_data[n];
      end
    return r;
  endfunction

  // Traps first by lowest index, then interrupts with bit 31 set
  function automatic du_pkg::word_t ref_cause(input du_pkg::exc_vec_t vec,
                                              input du_pkg::word_t prev);
    du_pkg::word_t r;
    int            i;
    r = prev;
    if (vec[15:0] != 16'h0)
    begin
      i = 0;
      while (!vec[i]) i++;
      r = du_pkg::word_t'(i);
    end
    else if (vec[31:16] != 16'h0)
    begin
      i = 16;
      while (!vec[i]) i++;
      r = 32'h8000_0000 | du_pkg::word_t'(i - 16);
    end
    return r;
  endfunction

  function automatic logic ref_mem_hit(input du_pkg::bp_cc_e cc, input du_pkg::opcode_t opc,
                                       input logic ack, input logic exc, input logic bubble,
                                       input logic adr_ok);
    logic valid;
    logic hit;
    valid = ack & ~exc & ~bubble & adr_ok;
    hit   = 1'b0;
    if (valid && opc == `DU_OPC_LOAD)
      hit = (cc == du_pkg::CC_LD_ADR) || (cc == du_pkg::CC_LDST_ADR);
    if (valid && opc == `DU_OPC_STORE)
      hit = (cc == du_pkg::CC_ST_ADR) || (cc == du_pkg::CC_LDST_ADR);
    return hit;
  endfunction

  task automatic apply_write(input du_pkg::dbg_addr_t addr, input du_pkg::word_t data);
    du_pkg::reg_ofs_t ofs;
    ofs = addr[`DU_REG_W-1:0];
    if (addr[`DU_ADDR_W-1:`DU_REG_W] == `DU_BANK_INTERNAL)
    begin
      if (ofs == `DU_REG_CTRL) sh_ctrl = data[1:0];
      if (ofs == `DU_REG_HIT) sh_hit = data & HitMask;
      if (ofs == `DU_REG_IE) sh_ie = data;
      if (ofs == `DU_REG_CAUSE) sh_cause = data;
      for (int n = 0; n < `DU_BREAKPOINTS; n++)
      begin
        if (ofs == du_pkg::reg_ofs_t'(`DU_REG_BPCTRL0 + 2 * n))
        begin
          sh_en[n] = data[1];
          sh_cc[n] = data[6:4];
        end
        if (ofs == du_pkg::reg_ofs_t'(`DU_REG_BPDATA0 + 2 * n))
          sh_data[n] = data;
      end
    end
  endtask

  //////////////////////////////
  // Checks and host port
  //////////////////////////////

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input du_pkg::word_t got,
                            input du_pkg::word_t exp);
    if (got !== exp)
      fail_stop($sformatf("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_stop($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic host_access(input logic we, input du_pkg::dbg_addr_t addr,
                             input du_pkg::word_t data, output du_pkg::word_t q);
    int cycles;
    dbg_strb_i = 1'b1;
    dbg_we_i   = we;
    dbg_addr_i = addr;
    dbg_d_i    = data;
    cycles     = 0;
    while (!dbg_ack_o)
    begin
      if (cycles == 20)
        fail_stop("no acknowledge on the debug port within 20 cycles");
      step_cycle();
      cycles++;
    end
    q          = dbg_q_o;
    dbg_strb_i = 1'b0;
    dbg_we_i   = 1'b0;
    // Strobe low for one cycle between accesses
    step_cycle();
  endtask

  task automatic write_reg(input du_pkg::dbg_addr_t addr, input du_pkg::word_t data);
    du_pkg::word_t q;
    host_access(1'b1, addr, data, q);
    apply_write(addr, data);
  endtask

  task automatic read_check(input string name, input du_pkg::dbg_addr_t addr);
    du_pkg::word_t q;
    host_access(1'b0, addr, '0, q);
    check_word(name, q, ref_rdata(addr));
  endtask

  // Fixed window of four cycles, first sample just after the input change
  task automatic count_pulses(output int n_latch, output int n_flush);
    n_latch = 0;
    n_flush = 0;
    #1;
    for (int i = 0; i < 4; i++)
    begin
      if (du_latch_nxt_pc_o) n_latch++;
      if (du_flush_o) n_flush++;
      step_cycle();
    end
  endtask

  task automatic clear_config();
    write_reg(internal_addr(`DU_REG_CTRL), '0);
    for (int n = 0; n < `DU_BREAKPOINTS; n++)
      write_reg(bpctrl_addr(n), '0);
    write_reg(internal_addr(`DU_REG_HIT), '0);
  endtask

  initial
  begin
    du_pkg::word_t    pc;
    du_pkg::word_t    adr;
    du_pkg::exc_vec_t vec;
    du_pkg::bp_cc_e   cc;
    du_pkg::opcode_t  opc;
    int               cycles;
    int               shamt;
    int               n_latch;
    int               n_flush;
    logic             ack_seen;
    void'($urandom(32'h9765));
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    dbg_stall_i     = 1'b0;
    dbg_strb_i      = 1'b0;
    dbg_we_i        = 1'b0;
    dbg_addr_i      = '0;
    dbg_d_i         = '0;
    pd_pc_i         = '0;
    bu_flush_i      = 1'b0;
    st_flush_i      = 1'b0;
    if_opcode_i     = `DU_OPC_LOAD;
    if_bubble_i     = 1'b1;
    mem_opcode_i    = `DU_OPC_LOAD;
    mem_bubble_i    = 1'b1;
    mem_exception_i = 1'b0;
    mem_adr_i       = '0;
    dmem_ack_i      = 1'b0;
    du_exceptions_i = '0;
    sh_ctrl         = '0;
    sh_ie           = '0;
    sh_cause        = '0;
    sh_hit          = '0;
    for (int n = 0; n < `DU_BREAKPOINTS; n++)
    begin
      sh_en[n]   = 1'b0;
      sh_cc[n]   = 3'd0;
      sh_data[n] = '0;
    end
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    check_bit("dbg_ack_o", dbg_ack_o, 1'b0);
    check_bit("dbg_bp_o", dbg_bp_o, 1'b0);
    check_bit("du_stall_o", du_stall_o, 1'b0);
    check_bit("du_flush_o", du_flush_o, 1'b0);

    // Random register contents, then full readback
    write_reg(internal_addr(`DU_REG_CTRL), $urandom);
    write_reg(internal_addr(`DU_REG_IE), $urandom);
    write_reg(internal_addr(`DU_REG_CAUSE), $urandom);
    for (int n = 0; n < `DU_MAX_BP; n++)
    begin
      write_reg(bpctrl_addr(n), $urandom);
      write_reg(bpdata_addr(n), $urandom);
    end
    read_check("CTRL", internal_addr(`DU_REG_CTRL));
    read_check("IE", internal_addr(`DU_REG_IE));
    read_check("CAUSE", internal_addr(`DU_REG_CAUSE));
    for (int n = 0; n < `DU_MAX_BP; n++)
    begin
      read_check($sformatf("BPCTRL%0d", n), bpctrl_addr(n));
      read_check($sformatf("BPDATA%0d", n), bpdata_addr(n));
    end
    read_check("unused offset", internal_addr(12'h005));
    check_word("du_ie_o", du_ie_o, sh_ie);
    clear_config();

    //////////////////////////////
    // Fetch breakpoint on bp1
    //////////////////////////////
    pc = $urandom | 32'h4;
    write_reg(bpdata_addr(1), pc);
    write_reg(bpctrl_addr(1), {25'b0, du_pkg::CC_FETCH, 4'b0010});
    pd_pc_i = pc;
    cycles  = 0;
    while (!(du_stall_o && dbg_bp_o))
    begin
      if (cycles == 3)
        fail_stop("fetch breakpoint gave no stall and no breakpoint pulse within 3 cycles");
      step_cycle();
      cycles++;
    end
    pd_pc_i = '0;
    // bp1 reports at bit 9
    sh_hit  = sh_hit | 32'h0000_0200;
    read_check("HIT", internal_addr(`DU_REG_HIT));
    write_reg(internal_addr(`DU_REG_HIT), '0);
    bu_flush_i = 1'b1;
    pd_pc_i    = pc;
    repeat (3) step_cycle();
    check_bit("du_stall_o", du_stall_o, 1'b0);
    read_check("HIT", internal_addr(`DU_REG_HIT));
    bu_flush_i = 1'b0;
    pd_pc_i    = '0;
    write_reg(bpctrl_addr(1), '0);

    // Memory conditions on bp0 against every qualifier
    adr = $urandom | 32'h1;
    write_reg(bpdata_addr(0), adr);
    for (int c = 0; c < 3; c++)
    begin
      cc = (c == 0) ? du_pkg::CC_LD_ADR : (c == 1) ? du_pkg::CC_ST_ADR : du_pkg::CC_LDST_ADR;
      write_reg(bpctrl_addr(0), {25'b0, cc, 4'b0010});
      for (int o = 0; o < 3; o++)
        for (int m = 0; m < 16; m++)
        begin
          opc = (o == 0) ? `DU_OPC_LOAD : (o == 1) ? `DU_OPC_STORE : `DU_OPC_BRANCH;
          mem_opcode_i    = opc;
          dmem_ack_i      = m[0];
          mem_exception_i = m[1];
          mem_bubble_i    = m[2];
          mem_adr_i       = m[3] ? adr : ~adr;
          step_cycle();
          dmem_ack_i      = 1'b0;
          mem_exception_i = 1'b0;
          mem_bubble_i    = 1'b1;
          mem_adr_i       = '0;
          if (ref_mem_hit(cc, opc, m[0], m[1], m[2], m[3]))
            sh_hit = sh_hit | 32'h0000_0100;
          read_check("HIT", internal_addr(`DU_REG_HIT));
          if (sh_hit != '0)
            write_reg(internal_addr(`DU_REG_HIT), '0);
        end
    end
    mem_opcode_i = `DU_OPC_LOAD;
    write_reg(bpctrl_addr(0), '0);

    // Single-cycle exception vectors
    for (int k = 0; k < 16; k++)
    begin
      shamt           = $urandom % 32;
      vec             = ($urandom | 32'h1) << shamt;
      du_exceptions_i = vec;
      step_cycle();
      du_exceptions_i = '0;
      check_bit("dbg_bp_o", dbg_bp_o, 1'b1);
      sh_cause = ref_cause(vec, sh_cause);
      read_check("CAUSE", internal_addr(`DU_REG_CAUSE));
    end

    //////////////////////////////
    // Debug entry and exit
    //////////////////////////////
    dbg_stall_i = 1'b1;
    count_pulses(n_latch, n_flush);
    check_word("du_latch_nxt_pc_o pulses", du_pkg::word_t'(n_latch), 32'd1);
    check_word("du_flush_o pulses", du_pkg::word_t'(n_flush), 32'd0);
    check_bit("du_stall_o", du_stall_o, 1'b1);
    write_reg(16'h1002, $urandom);
    read_check("bank 1", 16'h1002);
    read_check("IE", internal_addr(`DU_REG_IE));

    // Halted CPU, non-bubble fetches then a branch
    write_reg(internal_addr(`DU_REG_CTRL), 32'h3);
    if_opcode_i = `DU_OPC_BRANCH;
    step_cycle();
    read_check("HIT", internal_addr(`DU_REG_HIT));
    if_opcode_i = `DU_OPC_LOAD;
    if_bubble_i = 1'b0;
    step_cycle();
    if_bubble_i = 1'b1;
    sh_hit      = sh_hit | 32'h1;
    read_check("HIT", internal_addr(`DU_REG_HIT));
    if_opcode_i = `DU_OPC_BRANCH;
    if_bubble_i = 1'b0;
    step_cycle();
    if_bubble_i = 1'b1;
    if_opcode_i = `DU_OPC_LOAD;
    sh_hit      = sh_hit | 32'h3;
    read_check("HIT", internal_addr(`DU_REG_HIT));
    write_reg(internal_addr(`DU_REG_HIT), '0);
    read_check("HIT", internal_addr(`DU_REG_HIT));
    write_reg(internal_addr(`DU_REG_CTRL), '0);

    dbg_stall_i = 1'b0;
    count_pulses(n_latch, n_flush);
    check_word("du_latch_nxt_pc_o pulses", du_pkg::word_t'(n_latch), 32'd0);
    check_word("du_flush_o pulses", du_pkg::word_t'(n_flush), 32'd1);
    check_bit("du_stall_o", du_stall_o, 1'b0);

    // Other banks stay silent while the CPU runs
    dbg_strb_i = 1'b1;
    dbg_addr_i = 16'h2000;
    ack_seen   = 1'b0;
    repeat (8)
    begin
      step_cycle();
      ack_seen = ack_seen | dbg_ack_o;
    end
    dbg_strb_i = 1'b0;
    check_bit("dbg_ack_o", ack_seen, 1'b0);
    step_cycle();

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/du_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "du_params.svh"

module du_top (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  // Host debug port
  input  wire logic              dbg_stall_i,
  input  wire logic              dbg_strb_i,
  input  wire logic              dbg_we_i,
  input  wire du_pkg::dbg_addr_t dbg_addr_i,
  input  wire du_pkg::word_t     dbg_d_i,
  output du_pkg::word_t          dbg_q_o,
  output logic                   dbg_ack_o,
  output logic                   dbg_bp_o,
  // CPU side
  output logic                   du_stall_o,
  output logic                   du_latch_nxt_pc_o,
  output logic                   du_flush_o,
  output du_pkg::word_t          du_ie_o,
  input  wire du_pkg::word_t     pd_pc_i,
  input  wire logic              bu_flush_i,
  input  wire logic              st_flush_i,
  input  wire du_pkg::opcode_t   if_opcode_i,
  input  wire logic              if_bubble_i,
  input  wire du_pkg::opcode_t   mem_opcode_i,
  input  wire logic              mem_bubble_i,
  input  wire logic              mem_exception_i,
  input  wire du_pkg::word_t     mem_adr_i,
  input  wire logic              dmem_ack_i,
  input  wire du_pkg::exc_vec_t  du_exceptions_i
);

  logic             wr_en;
  du_pkg::reg_ofs_t wr_ofs;
  du_pkg::word_t    wr_data;
  logic             rd_internal;
  du_pkg::bp_vec_t  bp_hit;
  logic             instr_hit;
  logic             branch_hit;
  du_pkg::word_t    hit;
  du_pkg::word_t    cause;

  du_bp_if bp_if ();

  du_access_decode access_decode_inst (
    .clk_i, .rst_ni, .dbg_stall_i, .dbg_strb_i, .dbg_we_i, .dbg_addr_i, .dbg_d_i,
    .wr_ofs_o(wr_ofs), .wr_data_o(wr_data), .wr_en_o(wr_en),
    .rd_internal_o(rd_internal), .dbg_ack_o
  );

  du_regs regs_inst (
    .clk_i, .rst_ni, .wr_en_i(wr_en), .wr_ofs_i(wr_ofs), .wr_data_i(wr_data),
    .du_exceptions_i, .bp_o(bp_if.src), .ie_o(du_ie_o), .cause_o(cause)
  );

  du_bp_match bp_match_inst (
    .bp_i(bp_if.match), .pd_pc_i, .bu_flush_i, .st_flush_i, .if_opcode_i, .if_bubble_i,
    .mem_opcode_i, .mem_bubble_i, .mem_exception_i, .mem_adr_i, .dmem_ack_i,
    .bp_hit_o(bp_hit), .instr_hit_o(instr_hit), .branch_hit_o(branch_hit)
  );

  du_hit_ctrl hit_ctrl_inst (
    .clk_i, .rst_ni, .dbg_stall_i, .st_flush_i,
    .wr_en_i(wr_en), .wr_ofs_i(wr_ofs), .wr_data_i(wr_data),
    .bp_hit_i(bp_hit), .instr_hit_i(instr_hit), .branch_hit_i(branch_hit),
    .du_exceptions_i, .hit_o(hit), .du_stall_o, .du_latch_nxt_pc_o, .du_flush_o, .dbg_bp_o
  );

  // Read offset is the registered host offset
  du_readback readback_inst (
    .clk_i, .rd_ofs_i(wr_ofs), .rd_internal_i(rd_internal), .bp_i(bp_if.match),
    .hit_i(hit), .ie_i(du_ie_o), .cause_i(cause), .dbg_q_o
  );

endmodule

`default_nettype wire

// ==== rtl/du_readback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "du_params.svh"

module du_readback (
  input  wire logic             clk_i,
  input  wire du_pkg::reg_ofs_t rd_ofs_i,
  input  wire logic             rd_internal_i,
  du_bp_if.match                bp_i,
  input  wire du_pkg::word_t    hit_i,
  input  wire du_pkg::word_t    ie_i,
  input  wire du_pkg::word_t    cause_i,
  output du_pkg::word_t         dbg_q_o
);

  du_pkg::word_t rd_data;

  always_comb
  begin
    logic impl;
    rd_data = '0;
    if (rd_internal_i)
      case (rd_ofs_i)
        `DU_REG_CTRL:  rd_data = {30'b0, bp_i.branch_break_ena, bp_i.instr_break_ena};
        `DU_REG_HIT:   rd_data = hit_i;
        `DU_REG_IE:    rd_data = ie_i;
        `DU_REG_CAUSE: rd_data = cause_i;
        default:
          // Breakpoint slots, unknown offsets stay zero
          for (int n = 0; n < `DU_MAX_BP; n++)
          begin
            impl = n < `DU_BREAKPOINTS;
            if (rd_ofs_i == du_pkg::reg_ofs_t'(`DU_REG_BPCTRL0 + 2 * n))
              rd_data = {25'b0, bp_i.bp_cc[n], 2'b0, bp_i.bp_enabled[n], impl};
            if (rd_ofs_i == du_pkg::reg_ofs_t'(`DU_REG_BPDATA0 + 2 * n))
              rd_data = bp_i.bp_data[n];
          end
      endcase
  end

  always_ff @(posedge clk_i)
    dbg_q_o <= rd_data;

endmodule

`default_nettype wire

// ==== rtl/du_hit_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "du_params.svh"

module du_hit_ctrl (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             dbg_stall_i,
  input  wire logic             st_flush_i,
  input  wire logic             wr_en_i,
  input  wire du_pkg::reg_ofs_t wr_ofs_i,
  input  wire du_pkg::word_t    wr_data_i,
  input  wire du_pkg::bp_vec_t  bp_hit_i,
  input  wire logic             instr_hit_i,
  input  wire logic             branch_hit_i,
  input  wire du_pkg::exc_vec_t du_exceptions_i,
  output du_pkg::word_t         hit_o,
  output logic                  du_stall_o,
  output logic                  du_latch_nxt_pc_o,
  output logic                  du_flush_o,
  output logic                  dbg_bp_o
);

  localparam du_pkg::bp_vec_t BpImplMask = du_pkg::bp_vec_t'((1 << `DU_BREAKPOINTS) - 1);

  logic            ss_hit_q;
  logic            br_hit_q;
  du_pkg::bp_vec_t bp_hit_q;
  logic            stall_dly;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ss_hit_q <= 1'b0;
      br_hit_q <= 1'b0;
      bp_hit_q <= '0;
    end
    else if (wr_en_i && wr_ofs_i == `DU_REG_HIT)
    begin
      ss_hit_q <= wr_data_i[0];
      br_hit_q <= wr_data_i[1];
      bp_hit_q <= wr_data_i[8 +: `DU_MAX_BP] & BpImplMask;
    end
    else
    begin
      ss_hit_q <= instr_hit_i | (ss_hit_q & dbg_stall_i);
      br_hit_q <= branch_hit_i | (br_hit_q & dbg_stall_i);
      // Breakpoint hits stay until the host clears them
      bp_hit_q <= bp_hit_q | bp_hit_i;
    end
  end

  assign hit_o = {{(`DU_XLEN-8-`DU_MAX_BP){1'b0}}, bp_hit_q, 6'b0, br_hit_q, ss_hit_q};

  //////////////////////////////
  // CPU side
  //////////////////////////////

  assign du_stall_o = dbg_stall_i | (|hit_o);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      stall_dly <= 1'b0;
      dbg_bp_o  <= 1'b0;
    end
    else
    begin
      stall_dly <= dbg_stall_i;
      dbg_bp_o  <= ~du_flush_o & ~st_flush_i & ((|hit_o) | (|du_exceptions_i));
    end
  end

  // Entry latches the next PC, exit flushes the pipeline
  assign du_latch_nxt_pc_o = dbg_stall_i & ~stall_dly;
  assign du_flush_o        = ~dbg_stall_i & stall_dly;

  // Unimplemented slots never match
  bp_hit_impl_only: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bp_hit_i & ~BpImplMask) == '0);

endmodule

`default_nettype wire

// ==== rtl/du_bp_match.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "du_params.svh"

module du_bp_match (
  du_bp_if.match                bp_i,
  input  wire du_pkg::word_t    pd_pc_i,
  input  wire logic             bu_flush_i,
  input  wire logic             st_flush_i,
  input  wire du_pkg::opcode_t  if_opcode_i,
  input  wire logic             if_bubble_i,
  input  wire du_pkg::opcode_t  mem_opcode_i,
  input  wire logic             mem_bubble_i,
  input  wire logic             mem_exception_i,
  input  wire du_pkg::word_t    mem_adr_i,
  input  wire logic             dmem_ack_i,
  output du_pkg::bp_vec_t       bp_hit_o,
  output logic                  instr_hit_o,
  output logic                  branch_hit_o
);

  logic mem_read;
  logic mem_write;

  // Single step and branch break on the fetch stage
  assign instr_hit_o  = bp_i.instr_break_ena & ~if_bubble_i;
  assign branch_hit_o = bp_i.branch_break_ena & ~if_bubble_i
                      & (if_opcode_i == `DU_OPC_BRANCH);

  // Valid memory instruction in flight
  assign mem_read  = ~mem_exception_i & ~mem_bubble_i & (mem_opcode_i == `DU_OPC_LOAD);
  assign mem_write = ~mem_exception_i & ~mem_bubble_i & (mem_opcode_i == `DU_OPC_STORE);

  always_comb
  begin
    logic adr_eq;
    bp_hit_o = '0;
    for (int n = 0; n < `DU_MAX_BP; n++)
    begin
      adr_eq = (mem_adr_i == bp_i.bp_data[n]) & dmem_ack_i;
      if (bp_i.bp_enabled[n])
        case (bp_i.bp_cc[n])
          du_pkg::CC_FETCH:
            bp_hit_o[n] = (pd_pc_i == bp_i.bp_data[n]) & ~bu_flush_i & ~st_flush_i;
          du_pkg::CC_LD_ADR:   bp_hit_o[n] = adr_eq & mem_read;
          du_pkg::CC_ST_ADR:   bp_hit_o[n] = adr_eq & mem_write;
          du_pkg::CC_LDST_ADR: bp_hit_o[n] = adr_eq & (mem_read | mem_write);
          default:             bp_hit_o[n] = 1'b0;
        endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/du_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "du_params.svh"

module du_regs (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             wr_en_i,
  input  wire du_pkg::reg_ofs_t wr_ofs_i,
  input  wire du_pkg::word_t    wr_data_i,
  input  wire du_pkg::exc_vec_t du_exceptions_i,
  du_bp_if.src                  bp_o,
  output du_pkg::word_t         ie_o,
  output du_pkg::word_t         cause_o
);

  logic instr_ena_q;
  logic branch_ena_q;

  // Index of the lowest set bit, zero when none is set
  function automatic logic [3:0] lowest_set(input logic [15:0] v);
    logic [3:0] idx;
    idx = 4'd0;
    for (int i = 15; i >= 0; i--)
      if (v[i]) idx = 4'(i);
    return idx;
  endfunction

  //////////////////////////////
  // CTRL and IE
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      instr_ena_q  <= 1'b0;
      branch_ena_q <= 1'b0;
      ie_o         <= '0;
    end
    else if (wr_en_i)
    begin
      if (wr_ofs_i == `DU_REG_CTRL)
      begin
        instr_ena_q  <= wr_data_i[0];
        branch_ena_q <= wr_data_i[1];
      end
      if (wr_ofs_i == `DU_REG_IE)
        ie_o <= wr_data_i;
    end
  end

  assign bp_o.instr_break_ena  = instr_ena_q;
  assign bp_o.branch_break_ena = branch_ena_q;

  // Host write wins, then traps, then interrupts
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      cause_o <= '0;
    else if (wr_en_i && wr_ofs_i == `DU_REG_CAUSE)
      cause_o <= wr_data_i;
    else if (|du_exceptions_i[15:0])
      cause_o <= du_pkg::word_t'(lowest_set(du_exceptions_i[15:0]));
    else if (|du_exceptions_i[31:16])
      cause_o <= {1'b1, {(`DU_XLEN-5){1'b0}}, lowest_set(du_exceptions_i[31:16])};
  end

  //////////////////////////////
  // Breakpoint slots
  //////////////////////////////

  for (genvar n = 0; n < `DU_MAX_BP; n++)
  begin : gen_bp
    if (n < `DU_BREAKPOINTS)
    begin : gen_impl
      logic           en_q;
      du_pkg::bp_cc_e cc_q;
      du_pkg::word_t  data_q;

      always_ff @(posedge clk_i or negedge rst_ni)
      begin
        if (!rst_ni)
        begin
          en_q   <= 1'b0;
          cc_q   <= du_pkg::CC_FETCH;
          data_q <= '0;
        end
        else if (wr_en_i)
        begin
          if (wr_ofs_i == du_pkg::reg_ofs_t'(`DU_REG_BPCTRL0 + 2 * n))
          begin
            en_q <= wr_data_i[1];
            cc_q <= du_pkg::bp_cc_e'(wr_data_i[6:4]);
          end
          if (wr_ofs_i == du_pkg::reg_ofs_t'(`DU_REG_BPDATA0 + 2 * n))
            data_q <= wr_data_i;
        end
      end

      assign bp_o.bp_enabled[n] = en_q;
      assign bp_o.bp_cc[n]      = cc_q;
      assign bp_o.bp_data[n]    = data_q;
    end
    else
    begin : gen_unimpl
      assign bp_o.bp_enabled[n] = 1'b0;
      assign bp_o.bp_cc[n]      = du_pkg::CC_FETCH;
      assign bp_o.bp_data[n]    = '0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/du_access_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "du_params.svh"

module du_access_decode (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              dbg_stall_i,
  input  wire logic              dbg_strb_i,
  input  wire logic              dbg_we_i,
  input  wire du_pkg::dbg_addr_t dbg_addr_i,
  input  wire du_pkg::word_t     dbg_d_i,
  output du_pkg::reg_ofs_t       wr_ofs_o,
  output du_pkg::word_t          wr_data_o,
  output logic                   wr_en_o,
  output logic                   rd_internal_o,
  output logic                   dbg_ack_o
);

  logic       strb_dly;
  logic       sel_internal;
  logic       access;
  logic       wr_pulse;
  logic [2:0] ack_sr;

  // Bank select from the upper address bits
  assign sel_internal = dbg_addr_i[`DU_ADDR_W-1:`DU_REG_W] == `DU_BANK_INTERNAL;

  // Other banks only answer while the CPU is halted
  assign access   = dbg_strb_i & (sel_internal | dbg_stall_i);
  assign wr_pulse = access & ~strb_dly & dbg_we_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      strb_dly      <= 1'b0;
      wr_en_o       <= 1'b0;
      rd_internal_o <= 1'b0;
    end
    else
    begin
      strb_dly      <= dbg_strb_i;
      wr_en_o       <= wr_pulse & sel_internal;
      rd_internal_o <= sel_internal;
    end
  end

  always_ff @(posedge clk_i)
  begin
    wr_ofs_o  <= dbg_addr_i[`DU_REG_W-1:0];
    wr_data_o <= dbg_d_i;
  end

  //////////////////////////////
  // Acknowledge, third edge after the access
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ack_sr <= 3'b000;
    else
      ack_sr <= {3{access & ~dbg_ack_o}} & {1'b1, ack_sr[2:1]};
  end

  assign dbg_ack_o = ack_sr[0];

  // Host keeps the address steady while the strobe waits for the acknowledge
  strb_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_strb_i && !dbg_ack_o |=> !dbg_strb_i || $stable(dbg_addr_i));

endmodule

`default_nettype wire

// ==== rtl/du_bp_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "du_params.svh"

// Breakpoint and break-enable configuration from the register bank
interface du_bp_if;
  du_pkg::bp_vec_t bp_enabled;
  du_pkg::bp_cc_e  bp_cc   [`DU_MAX_BP];
  du_pkg::word_t   bp_data [`DU_MAX_BP];
  logic            instr_break_ena;
  logic            branch_break_ena;

  modport src   (output bp_enabled, bp_cc, bp_data, instr_break_ena, branch_break_ena);
  modport match (input  bp_enabled, bp_cc, bp_data, instr_break_ena, branch_break_ena);
endinterface

`default_nettype wire

// ==== rtl/du_pkg.sv ====
`default_nettype none

`include "du_params.svh"

package du_pkg;

  //////////////////////////////
  // Word types
  //////////////////////////////

  // Data word, also used for addresses and PCs
  typedef logic [`DU_XLEN-1:0]   word_t;

  // Host debug address, bank in the upper bits
  typedef logic [`DU_ADDR_W-1:0] dbg_addr_t;

  // Offset inside a bank
  typedef logic [`DU_REG_W-1:0]  reg_ofs_t;

  // Instruction bits 6:2
  typedef logic [4:0]            opcode_t;

  // Traps in 15:0, interrupts in 31:16
  typedef logic [31:0]           exc_vec_t;

  // One bit per breakpoint slot
  typedef logic [`DU_MAX_BP-1:0] bp_vec_t;

  //////////////////////////////
  // Breakpoint condition code
  //////////////////////////////

  typedef enum logic [2:0] {
    CC_FETCH    = 3'd0,
    CC_LD_ADR   = 3'd4,
    CC_ST_ADR   = 3'd5,
    CC_LDST_ADR = 3'd6
  } bp_cc_e;

endpackage

`default_nettype wire

// ==== include/du_params.svh ====
`ifndef DU_PARAMS_SVH
`define DU_PARAMS_SVH

// Data path and host address widths
`define DU_XLEN          32
`define DU_ADDR_W        16
`define DU_REG_W         12

// Bank select in the upper address bits
`define DU_BANK_INTERNAL 4'h0

// Breakpoint slots
`define DU_MAX_BP        8
`define DU_BREAKPOINTS   3

// Internal register offsets, breakpoint n at base + 2n
`define DU_REG_CTRL      12'h000
`define DU_REG_HIT       12'h001
`define DU_REG_IE        12'h002
`define DU_REG_CAUSE     12'h003
`define DU_REG_BPCTRL0   12'h010
`define DU_REG_BPDATA0   12'h011

// Instruction bits 6:2
`define DU_OPC_LOAD      5'b00000
`define DU_OPC_STORE     5'b01000
`define DU_OPC_BRANCH    5'b11000

`endif
